// ==== common/tlb_lookup_if.sv ====
`timescale 1ns/1ps

interface tlb_lookup_if;

    logic [tlb_pkg::VPN2_W-1:0]    vpn2;
    logic [tlb_pkg::ASID_W-1:0]    asid;
    logic                          hit;
    logic [tlb_pkg::TLB_IDX_W-1:0] hit_idx;
    tlb_pkg::tlb_entry_t           entry;   // Entry 0 on a miss

    modport requester (
        output vpn2, asid,
        input  hit, hit_idx, entry
    );

    modport matcher (
        input  vpn2, asid,
        output hit, hit_idx, entry
    );

endinterface

// ==== common/tlb_pkg.sv ====
package tlb_pkg;

    localparam int TLB_N      = 16;
    localparam int TLB_IDX_W  = 4;
    localparam int ADDR_W     = 32;
    localparam int VPN2_W     = 19;
    localparam int PFN_W      = 20;
    localparam int ASID_W     = 8;
    localparam int PAGE_OFS_W = 12;
    localparam int CACHE_AT_W = 3;

    localparam logic [CACHE_AT_W-1:0] CACHEABLE_CODE  = 3'd3;
    localparam logic [ADDR_W-1:0]     PROBE_MISS_WORD = 32'h8000_0000; // P bit only

    // EntryHi layout
    localparam int EH_VPN2_LO = 13;
    localparam int EH_VPN2_HI = EH_VPN2_LO + VPN2_W - 1;
    localparam int EH_ASID_LO = 0;
    localparam int EH_ASID_HI = EH_ASID_LO + ASID_W - 1;

    // EntryLo layout
    localparam int EL_PFN_LO = 6;
    localparam int EL_PFN_HI = EL_PFN_LO + PFN_W - 1;
    localparam int EL_C_LO   = 3;
    localparam int EL_C_HI   = EL_C_LO + CACHE_AT_W - 1;
    localparam int EL_D      = 2;
    localparam int EL_V      = 1;
    localparam int EL_G      = 0;

    typedef enum logic [1:0] {
        TOP_NOP   = 2'd0,
        TOP_TLBR  = 2'd1,
        TOP_TLBWI = 2'd2,
        TOP_TLBP  = 2'd3
    } tlb_op_e;

    typedef enum logic [1:0] {
        XS_IDLE      = 2'd0,
        XS_TRANSLATE = 2'd1,
        XS_READY     = 2'd2,
        XS_HOLD      = 2'd3
    } xlate_state_e;

    typedef struct packed {
        logic [PFN_W-1:0]      pfn;
        logic [CACHE_AT_W-1:0] c;
        logic                  d;
        logic                  v;
    } tlb_page_t;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        tlb_page_t         page0; // Even page
        tlb_page_t         page1; // Odd page
    } tlb_entry_t;

endpackage

// ==== project.f ====
common/tlb_pkg.sv
common/tlb_lookup_if.sv
rtl/tlb_array.sv
rtl/tlb_match.sv
rtl/tlb_data_xlate.sv
rtl/tlb_cp0_ops.sv
rtl/tlb_top.sv
verif/tlb_checker.sv
verif/tlb_monitor.sv
verif/tb_tlb.sv

// ==== rtl/tlb_array.sv ====
`timescale 1ns/1ps

module tlb_array (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          i_we,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] i_widx,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_hi,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_lo0,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_lo1,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] i_ridx,
    output tlb_pkg::tlb_entry_t           o_entries [tlb_pkg::TLB_N],
    output tlb_pkg::tlb_entry_t           o_rentry
);

    tlb_pkg::tlb_entry_t mem [tlb_pkg::TLB_N];
    tlb_pkg::tlb_entry_t wentry;

    // Pack CP0 register fields into one entry
    always_comb begin
        wentry.vpn2       = i_entry_hi[tlb_pkg::EH_VPN2_HI:tlb_pkg::EH_VPN2_LO];
        wentry.asid       = i_entry_hi[tlb_pkg::EH_ASID_HI:tlb_pkg::EH_ASID_LO];
        wentry.g          = i_entry_lo0[tlb_pkg::EL_G] & i_entry_lo1[tlb_pkg::EL_G];
        wentry.page0.pfn  = i_entry_lo0[tlb_pkg::EL_PFN_HI:tlb_pkg::EL_PFN_LO];
        wentry.page0.c    = i_entry_lo0[tlb_pkg::EL_C_HI:tlb_pkg::EL_C_LO];
        wentry.page0.d    = i_entry_lo0[tlb_pkg::EL_D];
        wentry.page0.v    = i_entry_lo0[tlb_pkg::EL_V];
        wentry.page1.pfn  = i_entry_lo1[tlb_pkg::EL_PFN_HI:tlb_pkg::EL_PFN_LO];
        wentry.page1.c    = i_entry_lo1[tlb_pkg::EL_C_HI:tlb_pkg::EL_C_LO];
        wentry.page1.d    = i_entry_lo1[tlb_pkg::EL_D];
        wentry.page1.v    = i_entry_lo1[tlb_pkg::EL_V];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < tlb_pkg::TLB_N; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[i_widx] <= wentry; // TLBWI
        end
    end

    assign o_entries = mem;
    assign o_rentry  = mem[i_ridx];

endmodule

// ==== rtl/tlb_cp0_ops.sv ====
`timescale 1ns/1ps

module tlb_cp0_ops (
    input  logic                       clk,
    input  logic                       rst,
    input  tlb_pkg::tlb_op_e           i_op,
    input  tlb_pkg::tlb_entry_t        i_rentry,
    input  logic [tlb_pkg::ADDR_W-1:0] i_entry_hi,
    tlb_lookup_if.requester            pr,
    output logic                       o_tlbwen,
    output tlb_pkg::tlb_entry_t        o_entry,
    output logic                       o_idxwen,
    output logic [tlb_pkg::ADDR_W-1:0] o_index
);

    // Probe key straight from EntryHi
    assign pr.vpn2 = i_entry_hi[tlb_pkg::EH_VPN2_HI:tlb_pkg::EH_VPN2_LO];
    assign pr.asid = i_entry_hi[tlb_pkg::EH_ASID_HI:tlb_pkg::EH_ASID_LO];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_tlbwen <= 1'b0;
            o_entry  <= '0;
            o_idxwen <= 1'b0;
            o_index  <= '0;
        end else begin
            o_tlbwen <= 1'b0; // Single-cycle pulses
            o_idxwen <= 1'b0;
            case (i_op)
                tlb_pkg::TOP_TLBR: begin
                    o_tlbwen <= 1'b1;
                    o_entry  <= i_rentry;
                end
                tlb_pkg::TOP_TLBP: begin
                    o_idxwen <= 1'b1;
                    if (pr.hit) begin
                        o_index <= {{(tlb_pkg::ADDR_W - tlb_pkg::TLB_IDX_W){1'b0}}, pr.hit_idx};
                    end else begin
                        o_index <= tlb_pkg::PROBE_MISS_WORD;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/tlb_data_xlate.sv ====
`timescale 1ns/1ps

module tlb_data_xlate (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_en,
    input  logic [tlb_pkg::ADDR_W-1:0] i_vaddr,
    input  logic                       i_store,
    input  logic                       i_stall,
    input  logic                       i_op_nop,
    input  logic [tlb_pkg::ASID_W-1:0] i_asid,
    tlb_lookup_if.requester            lk,
    output logic                       o_rdy,
    output logic [tlb_pkg::ADDR_W-1:0] o_paddr,
    output logic                       o_cached,
    output logic                       o_refill,
    output logic                       o_invalid,
    output logic                       o_modified
);

    tlb_pkg::xlate_state_e      state;
    logic [tlb_pkg::ADDR_W-1:0] vaddr_q;
    logic [tlb_pkg::ASID_W-1:0] asid_q;
    logic                       store_q;
    tlb_pkg::tlb_entry_t        ent_q;
    tlb_pkg::tlb_page_t         page_sel;
    logic                       accept;

    assign accept = (state == tlb_pkg::XS_IDLE) && i_en && !o_rdy && i_op_nop;

    assign lk.vpn2 = vaddr_q[tlb_pkg::ADDR_W-1:tlb_pkg::EH_VPN2_LO];
    assign lk.asid = asid_q;

    // Bit 12 picks the odd page
    assign page_sel = vaddr_q[tlb_pkg::PAGE_OFS_W] ? ent_q.page1 : ent_q.page0;

    always_ff @(posedge clk) begin
        if (accept) begin
            vaddr_q <= i_vaddr;
            asid_q  <= i_asid;
            store_q <= i_store;
        end
        if (state == tlb_pkg::XS_TRANSLATE) begin
            ent_q <= lk.entry;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= tlb_pkg::XS_IDLE;
            o_rdy      <= 1'b0;
            o_paddr    <= '0;
            o_cached   <= 1'b0;
            o_refill   <= 1'b0;
            o_invalid  <= 1'b0;
            o_modified <= 1'b0;
        end else begin
            case (state)
                tlb_pkg::XS_IDLE: begin
                    if (accept) begin
                        state <= tlb_pkg::XS_TRANSLATE;
                    end
                end
                tlb_pkg::XS_TRANSLATE: begin
                    o_refill <= !lk.hit;
                    state    <= tlb_pkg::XS_READY;
                end
                tlb_pkg::XS_READY: begin
                    o_rdy      <= 1'b1;
                    o_paddr    <= {page_sel.pfn, vaddr_q[tlb_pkg::PAGE_OFS_W-1:0]};
                    o_cached   <= (page_sel.c == tlb_pkg::CACHEABLE_CODE);
                    o_invalid  <= !page_sel.v;
                    o_modified <= store_q && !page_sel.d;
                    state      <= tlb_pkg::XS_HOLD;
                end
                tlb_pkg::XS_HOLD: begin
                    if (!i_stall) begin // Requester has taken the result
                        o_rdy      <= 1'b0;
                        o_refill   <= 1'b0;
                        o_invalid  <= 1'b0;
                        o_modified <= 1'b0;
                        state      <= tlb_pkg::XS_IDLE;
                    end
                end
                default: state <= tlb_pkg::XS_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/tlb_match.sv ====
`timescale 1ns/1ps

module tlb_match (
    input  tlb_pkg::tlb_entry_t i_entries [tlb_pkg::TLB_N],
    tlb_lookup_if.matcher       lk
);

    logic [tlb_pkg::TLB_N-1:0]     hit_vec;
    logic [tlb_pkg::TLB_IDX_W-1:0] hit_idx;

    // Parallel compare against every entry
    always_comb begin
        for (int i = 0; i < tlb_pkg::TLB_N; i++) begin
            hit_vec[i] = (i_entries[i].vpn2 == lk.vpn2) &&
                         (i_entries[i].g || (i_entries[i].asid == lk.asid));
        end
    end

    // Scan downward so the lowest hit is left standing
    always_comb begin
        hit_idx = '0;
        for (int i = tlb_pkg::TLB_N - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = i[tlb_pkg::TLB_IDX_W-1:0];
            end
        end
    end

    assign lk.hit     = |hit_vec;
    assign lk.hit_idx = hit_idx;
    assign lk.entry   = i_entries[hit_idx]; // Index 0 on a miss

endmodule

// ==== rtl/tlb_top.sv ====
`timescale 1ns/1ps

module tlb_top (
    input  logic                          clk,
    input  logic                          rst,
    input  tlb_pkg::tlb_op_e              i_tlb_op,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] i_index,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_hi,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_lo0,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_lo1,
    input  logic                          i_dmmu_en,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_dmmu_vaddr,
    input  logic                          i_dmmu_store,
    input  logic                          i_dmmu_stall,
    output logic                          o_dmmu_rdy,
    output logic [tlb_pkg::ADDR_W-1:0]    o_dmmu_paddr,
    output logic                          o_dmmu_cached,
    output logic                          o_dmmu_refill,
    output logic                          o_dmmu_invalid,
    output logic                          o_dmmu_modified,
    output logic                          o_cp0_tlbwen,
    output tlb_pkg::tlb_entry_t           o_cp0_entry,
    output logic                          o_cp0_idxwen,
    output logic [tlb_pkg::ADDR_W-1:0]    o_cp0_index
);

    tlb_pkg::tlb_entry_t entries [tlb_pkg::TLB_N];
    tlb_pkg::tlb_entry_t rentry;

    tlb_lookup_if lk_if ();
    tlb_lookup_if pr_if ();

    tlb_array u_array (
        .clk         (clk),
        .rst         (rst),
        .i_we        (i_tlb_op == tlb_pkg::TOP_TLBWI),
        .i_widx      (i_index),
        .i_entry_hi  (i_entry_hi),
        .i_entry_lo0 (i_entry_lo0),
        .i_entry_lo1 (i_entry_lo1),
        .i_ridx      (i_index),
        .o_entries   (entries),
        .o_rentry    (rentry)
    );

    tlb_match u_match_lookup (
        .i_entries (entries),
        .lk        (lk_if.matcher)
    );

    tlb_match u_match_probe (
        .i_entries (entries),
        .lk        (pr_if.matcher)
    );

    tlb_data_xlate u_xlate (
        .clk        (clk),
        .rst        (rst),
        .i_en       (i_dmmu_en),
        .i_vaddr    (i_dmmu_vaddr),
        .i_store    (i_dmmu_store),
        .i_stall    (i_dmmu_stall),
        .i_op_nop   (i_tlb_op == tlb_pkg::TOP_NOP), // No lookup while a CP0 op runs
        .i_asid     (i_entry_hi[tlb_pkg::EH_ASID_HI:tlb_pkg::EH_ASID_LO]),
        .lk         (lk_if.requester),
        .o_rdy      (o_dmmu_rdy),
        .o_paddr    (o_dmmu_paddr),
        .o_cached   (o_dmmu_cached),
        .o_refill   (o_dmmu_refill),
        .o_invalid  (o_dmmu_invalid),
        .o_modified (o_dmmu_modified)
    );

    tlb_cp0_ops u_cp0_ops (
        .clk        (clk),
        .rst        (rst),
        .i_op       (i_tlb_op),
        .i_rentry   (rentry),
        .i_entry_hi (i_entry_hi),
        .pr         (pr_if.requester),
        .o_tlbwen   (o_cp0_tlbwen),
        .o_entry    (o_cp0_entry),
        .o_idxwen   (o_cp0_idxwen),
        .o_index    (o_cp0_index)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TLB testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module tb_tlb -f project.f --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_tlb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== verif/tb_tlb.sv ====
`timescale 1ns/1ps

module tb_tlb;

    localparam int WAIT_LIMIT = 32;

    typedef struct {
        tlb_pkg::tlb_op_e op;
        logic [31:0]      hi, lo0, lo1;
        logic [3:0]       idx;
        logic [31:0]      va;
        logic             st;
        int               stall;
    } row_t;

    logic                          clk, rst;
    tlb_pkg::tlb_op_e              i_tlb_op;
    logic [tlb_pkg::TLB_IDX_W-1:0] i_index;
    logic [tlb_pkg::ADDR_W-1:0]    i_entry_hi, i_entry_lo0, i_entry_lo1, i_dmmu_vaddr;
    logic                          i_dmmu_en, i_dmmu_store, i_dmmu_stall;
    logic                          o_dmmu_rdy, o_dmmu_cached, o_dmmu_refill;
    logic                          o_dmmu_invalid, o_dmmu_modified, o_cp0_tlbwen, o_cp0_idxwen;
    logic [tlb_pkg::ADDR_W-1:0]    o_dmmu_paddr, o_cp0_index;
    tlb_pkg::tlb_entry_t           o_cp0_entry;
    int                            mon_errors, timeouts;
    row_t                          rows [$];

    tlb_top u_tlb_top (.*);

    tlb_monitor u_monitor (.o_errors(mon_errors), .*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] hi_word(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    function automatic logic [31:0] lo_word(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    function automatic void add_row(input tlb_pkg::tlb_op_e op, input logic [31:0] hi,
                                    input logic [31:0] lo0, input logic [31:0] lo1,
                                    input logic [3:0] idx, input logic [31:0] va,
                                    input logic st);
        row_t r;
        r = '{op: op, hi: hi, lo0: lo0, lo1: lo1, idx: idx, va: va, st: st,
              stall: int'($urandom_range(3, 0))};
        rows.push_back(r);
    endfunction

    task automatic run_translation(input row_t r, input int n);
        int cnt;
        i_entry_hi   = r.hi;
        i_dmmu_vaddr = r.va;
        i_dmmu_store = r.st;
        i_dmmu_stall = (r.stall != 0);
        i_dmmu_en    = 1'b1;
        cnt = 0;
        while (!o_dmmu_rdy && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!o_dmmu_rdy) begin
            $display("Timeout: row %0d never saw o_dmmu_rdy rise", n);
            timeouts++;
        end else begin
            repeat (r.stall) begin // Keep the result for a while
                @(posedge clk);
                #1;
            end
        end
        i_dmmu_en    = 1'b0;
        i_dmmu_stall = 1'b0;
        cnt = 0;
        while (o_dmmu_rdy && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (o_dmmu_rdy) begin
            $display("Timeout: row %0d never saw o_dmmu_rdy fall", n);
            timeouts++;
        end
    endtask

    task automatic run_cp0_op(input row_t r, input int n);
        int cnt;
        i_tlb_op    = r.op;
        i_index     = r.idx;
        i_entry_hi  = r.hi;
        i_entry_lo0 = r.lo0;
        i_entry_lo1 = r.lo1;
        @(posedge clk);
        #1;
        i_tlb_op = tlb_pkg::TOP_NOP;
        if (r.op != tlb_pkg::TOP_TLBWI) begin
            cnt = 0;
            while (!(o_cp0_tlbwen || o_cp0_idxwen) && cnt < WAIT_LIMIT) begin
                @(posedge clk);
                #1;
                cnt++;
            end
            if (!(o_cp0_tlbwen || o_cp0_idxwen)) begin
                $display("Timeout: row %0d never saw a CP0 write pulse", n);
                timeouts++;
            end
        end
    endtask

    initial begin
        void'($urandom(125));
        rst          = 1'b1;
        i_tlb_op     = tlb_pkg::TOP_NOP;
        i_index      = '0;
        i_entry_hi   = '0;
        i_entry_lo0  = '0;
        i_entry_lo1  = '0;
        i_dmmu_en    = 1'b0;
        i_dmmu_vaddr = '0;
        i_dmmu_store = 1'b0;
        i_dmmu_stall = 1'b0;
        timeouts     = 0;

        // Nonzero ASID misses in the empty TLB
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h05), '0, '0, 4'd0, 32'h0000_1234, 1'b0);
        add_row(tlb_pkg::TOP_TLBWI, hi_word(19'h00040, 8'h05),
                lo_word(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
                lo_word(20'h0abcd, 3'd2, 1'b0, 1'b1, 1'b0), 4'd3, '0, 1'b0);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h05), '0, '0, 4'd0, 32'h0008_0123, 1'b0);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h05), '0, '0, 4'd0, 32'h0008_1456, 1'b0);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h05), '0, '0, 4'd0, 32'h0008_1456, 1'b1);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h05), '0, '0, 4'd0, 32'h0008_0fff, 1'b1);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h07), '0, '0, 4'd0, 32'h0008_0010, 1'b0);
        add_row(tlb_pkg::TOP_TLBWI, hi_word(19'h00100, 8'h01),
                lo_word(20'h00777, 3'd3, 1'b1, 1'b0, 1'b1),
                lo_word(20'h00888, 3'd3, 1'b1, 1'b1, 1'b1), 4'd7, '0, 1'b0);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h09), '0, '0, 4'd0, 32'h0020_0004, 1'b0);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h09), '0, '0, 4'd0, 32'h0020_1008, 1'b0);
        add_row(tlb_pkg::TOP_TLBWI, hi_word(19'h00100, 8'h02),
                lo_word(20'h11111, 3'd3, 1'b1, 1'b1, 1'b0),
                lo_word(20'h22222, 3'd3, 1'b1, 1'b1, 1'b1), 4'd1, '0, 1'b0);
        add_row(tlb_pkg::TOP_TLBP, hi_word(19'h00100, 8'h02), '0, '0, 4'd0, '0, 1'b0);
        add_row(tlb_pkg::TOP_TLBP, hi_word(19'h00100, 8'h03), '0, '0, 4'd0, '0, 1'b0);
        add_row(tlb_pkg::TOP_TLBP, hi_word(19'h003ff, 8'h03), '0, '0, 4'd0, '0, 1'b0);
        add_row(tlb_pkg::TOP_TLBR, '0, '0, '0, 4'd1, '0, 1'b0);
        add_row(tlb_pkg::TOP_TLBR, '0, '0, '0, 4'd7, '0, 1'b0);
        add_row(tlb_pkg::TOP_NOP, hi_word(19'h0, 8'h02), '0, '0, 4'd0, 32'h0020_0004, 1'b0);

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[n]) begin
            @(posedge clk);
            #1;
            if (rows[n].op == tlb_pkg::TOP_NOP) begin
                run_translation(rows[n], n);
            end else begin
                run_cp0_op(rows[n], n);
            end
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d timeouts", mon_errors, timeouts);
        if (mon_errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verif/tlb_checker.sv ====
`timescale 1ns/1ps

module tlb_checker (
    input logic clk,
    input logic rst,
    input logic i_dmmu_en,
    input logic o_dmmu_rdy,
    input logic o_dmmu_refill,
    input logic o_dmmu_invalid,
    input logic o_dmmu_modified,
    input logic o_cp0_tlbwen,
    input logic o_cp0_idxwen
);

    // Result only while the request is up, or in the release cycle
    rdy_with_en: assert property (@(posedge clk) disable iff (rst)
        o_dmmu_rdy |-> (i_dmmu_en || $past(i_dmmu_en)))
        else $error("o_dmmu_rdy high without a pending i_dmmu_en");

    cp0_pulses_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_cp0_tlbwen && o_cp0_idxwen))
        else $error("o_cp0_tlbwen and o_cp0_idxwen high together");

    // Refill is set one edge ahead of rdy
    refill_then_rdy: assert property (@(posedge clk) disable iff (rst)
        (o_dmmu_refill && !o_dmmu_rdy) |=> o_dmmu_rdy)
        else $error("o_dmmu_refill high without o_dmmu_rdy following");

    flags_with_rdy: assert property (@(posedge clk) disable iff (rst)
        (o_dmmu_invalid || o_dmmu_modified) |-> o_dmmu_rdy)
        else $error("Exception flag high while o_dmmu_rdy is low");

endmodule

bind tlb_top tlb_checker u_checker (
    .clk             (clk),
    .rst             (rst),
    .i_dmmu_en       (i_dmmu_en),
    .o_dmmu_rdy      (o_dmmu_rdy),
    .o_dmmu_refill   (o_dmmu_refill),
    .o_dmmu_invalid  (o_dmmu_invalid),
    .o_dmmu_modified (o_dmmu_modified),
    .o_cp0_tlbwen    (o_cp0_tlbwen),
    .o_cp0_idxwen    (o_cp0_idxwen)
);

// ==== verif/tlb_monitor.sv ====
`timescale 1ns/1ps

module tlb_monitor (
    input  logic                          clk, rst,
    input  tlb_pkg::tlb_op_e              i_tlb_op,
    input  logic [tlb_pkg::TLB_IDX_W-1:0] i_index,
    input  logic [tlb_pkg::ADDR_W-1:0]    i_entry_hi, i_entry_lo0, i_entry_lo1, i_dmmu_vaddr,
    input  logic                          i_dmmu_en, i_dmmu_store, i_dmmu_stall,
    input  logic                          o_dmmu_rdy, o_dmmu_cached, o_dmmu_refill,
    input  logic                          o_dmmu_invalid, o_dmmu_modified,
    input  logic                          o_cp0_tlbwen, o_cp0_idxwen,
    input  logic [tlb_pkg::ADDR_W-1:0]    o_dmmu_paddr, o_cp0_index,
    input  tlb_pkg::tlb_entry_t           o_cp0_entry,
    output int                            o_errors
);

    tlb_pkg::tlb_entry_t        model [tlb_pkg::TLB_N];
    tlb_pkg::tlb_entry_t        exp_entry;
    tlb_pkg::tlb_page_t         pg;
    logic [tlb_pkg::ADDR_W-1:0] exp_index, exp_paddr;
    logic exp_tlbwen, exp_idxwen, exp_refill, exp_cached, exp_invalid, exp_modified;
    logic busy, checked, rst_checked, rdy_tracked, exp_rdy;
    int   idx;

    // Lowest matching entry or -1 on a miss
    function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] asid);
        for (int i = 0; i < tlb_pkg::TLB_N; i++) begin
            if (model[i].vpn2 == vpn2 && (model[i].g || model[i].asid == asid)) begin
                return i;
            end
        end
        return -1;
    endfunction

    // EntryLo is PFN[25:6] C[5:3] D V G
    function automatic tlb_pkg::tlb_page_t lo_to_page(input logic [31:0] lo);
        return '{pfn: lo[25:6], c: lo[5:3], d: lo[2], v: lo[1]};
    endfunction

    task automatic compare_value(input string name, input logic [75:0] exp_v,
                                 input logic [75:0] act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp_v, act_v);
            o_errors++;
        end
    endtask

    // Outputs here reflect the last edge while inputs belong to the next one
    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < tlb_pkg::TLB_N; i++) begin
                model[i] = '0;
            end
            exp_tlbwen  = 1'b0;
            exp_idxwen  = 1'b0;
            busy        = 1'b0;
            checked     = 1'b0;
            rst_checked = 1'b0;
            rdy_tracked = 1'b0;
            o_errors    = 0;
        end else begin
            if (!rst_checked) begin
                compare_value("control outputs after reset", '0, 76'({o_dmmu_rdy,
                    o_dmmu_cached, o_dmmu_refill, o_dmmu_invalid, o_dmmu_modified,
                    o_cp0_tlbwen, o_cp0_idxwen}));
                compare_value("o_dmmu_paddr after reset", '0, 76'(o_dmmu_paddr));
                compare_value("o_cp0_index after reset", '0, 76'(o_cp0_index));
                compare_value("o_cp0_entry after reset", '0, o_cp0_entry);
                rst_checked = 1'b1;
            end
            compare_value("o_cp0_tlbwen", 76'(exp_tlbwen), 76'(o_cp0_tlbwen));
            compare_value("o_cp0_idxwen", 76'(exp_idxwen), 76'(o_cp0_idxwen));
            if (exp_tlbwen) begin
                compare_value("o_cp0_entry", exp_entry, o_cp0_entry);
            end
            if (exp_idxwen) begin
                compare_value("o_cp0_index", 76'(exp_index), 76'(o_cp0_index));
            end
            if (rdy_tracked) begin
                compare_value("o_dmmu_rdy", 76'(exp_rdy), 76'(o_dmmu_rdy));
            end
            if (busy && o_dmmu_rdy) begin
                compare_value("o_dmmu_refill", 76'(exp_refill), 76'(o_dmmu_refill));
                if (!exp_refill) begin // Miss leaves the other outputs undefined
                    compare_value("o_dmmu_paddr", 76'(exp_paddr), 76'(o_dmmu_paddr));
                    compare_value("o_dmmu_cached", 76'(exp_cached), 76'(o_dmmu_cached));
                    compare_value("o_dmmu_invalid", 76'(exp_invalid), 76'(o_dmmu_invalid));
                    compare_value("o_dmmu_modified", 76'(exp_modified), 76'(o_dmmu_modified));
                end
                checked = 1'b1;
            end else if (busy && checked && !o_dmmu_rdy) begin
                busy = 1'b0;
            end else if (!busy && o_dmmu_rdy) begin
                compare_value("o_dmmu_rdy with no request", '0, 76'(o_dmmu_rdy));
            end
            rdy_tracked = busy && o_dmmu_rdy;
            exp_rdy     = i_dmmu_stall; // Stall keeps the result one more edge
            exp_tlbwen = (i_tlb_op == tlb_pkg::TOP_TLBR);
            exp_idxwen = (i_tlb_op == tlb_pkg::TOP_TLBP);
            if (exp_tlbwen) begin
                exp_entry = model[i_index];
            end
            if (exp_idxwen) begin
                idx       = find_entry(i_entry_hi[31:13], i_entry_hi[7:0]);
                exp_index = (idx < 0) ? tlb_pkg::PROBE_MISS_WORD : 32'(idx);
            end
            if (i_tlb_op == tlb_pkg::TOP_TLBWI) begin
                model[i_index].vpn2  = i_entry_hi[31:13];
                model[i_index].asid  = i_entry_hi[7:0];
                model[i_index].g     = i_entry_lo0[0] & i_entry_lo1[0]; // Both G bits
                model[i_index].page0 = lo_to_page(i_entry_lo0);
                model[i_index].page1 = lo_to_page(i_entry_lo1);
            end
            if (i_dmmu_en && !busy && !o_dmmu_rdy && i_tlb_op == tlb_pkg::TOP_NOP) begin
                busy       = 1'b1;
                checked    = 1'b0;
                idx        = find_entry(i_dmmu_vaddr[31:13], i_entry_hi[7:0]);
                exp_refill = (idx < 0);
                if (!exp_refill) begin
                    pg = i_dmmu_vaddr[12] ? model[idx].page1 : model[idx].page0;
                    exp_paddr    = {pg.pfn, i_dmmu_vaddr[11:0]};
                    exp_cached   = (pg.c == 3'd3);
                    exp_invalid  = !pg.v;
                    exp_modified = i_dmmu_store && !pg.d;
                end
            end
        end
    end

endmodule
